// File: test/memWbInput.txt
# instr pc aluResult storeData wrAddr expEn expAddr expData expPc readReg readValue
# all fields hex, one line per cycle, commit data checked only when expEn is 1
24020011 00000400 0000abcd 00000000 02 1 02 0000abcd 00000400 02 0000abcd
00221820 00000404 12345678 00000000 00 0 00 00000000 00000000 00 00000000
ac000000 00000408 00000100 11223344 00 0 00 00000000 00000000 02 0000abcd
8c000000 0000040c 00000100 00000000 03 1 03 11223344 0000040c 03 11223344
a0000000 00000410 00000100 00000080 00 0 00 00000000 00000000 03 11223344
a0000000 00000414 00000101 000000aa 00 0 00 00000000 00000000 00 00000000
a0000000 00000418 00000102 0000007f 00 0 00 00000000 00000000 02 0000abcd
a0000000 0000041c 00000103 000000be 00 0 00 00000000 00000000 03 11223344
8c000000 00000420 00000100 00000000 04 1 04 be7faa80 00000420 04 be7faa80
80000000 00000424 00000100 00000000 05 1 05 ffffff80 00000424 05 ffffff80
90000000 00000428 00000101 00000000 06 1 06 000000aa 00000428 06 000000aa
80000000 0000042c 00000102 00000000 07 1 07 0000007f 0000042c 07 0000007f
90000000 00000430 00000103 00000000 08 1 08 000000be 00000430 08 000000be
84000000 00000434 00000100 00000000 09 1 09 ffffaa80 00000434 09 ffffaa80
94000000 00000438 00000102 00000000 0a 1 0a 0000be7f 00000438 0a 0000be7f
a4000000 0000043c 00000104 1234fedc 00 0 00 00000000 00000000 00 00000000
a4000000 00000440 00000106 00008001 00 0 00 00000000 00000000 0a 0000be7f
94000000 00000444 00000104 00000000 0b 1 0b 0000fedc 00000444 0b 0000fedc
84000000 00000448 00000106 00000000 0c 1 0c ffff8001 00000448 0c ffff8001
00000000 0000044c 00000000 00000000 00 0 00 00000000 00000000 0c ffff8001
80000000 00000450 00000103 00000000 0d 1 0d ffffffbe 00000450 0d ffffffbe
84000000 00000454 00000104 00000000 0e 1 0e fffffedc 00000454 0e fffffedc

// File: verilog.f
+incdir+include
source/cpuPkg.sv
source/instrClassifier.sv
source/dataMemory.sv
source/loadExtender.sv
source/writeBackStage.sv
source/regFile.sv
source/memWbTop.sv
test/memWbTb.sv

// File: test/memWbTb.sv
`timescale 1ns/1ps

module memWbTb;

    localparam int HALF_PERIOD  = 2;  // 4 ns clock.
    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 10; // watchdog margin.

    // one line of the stimulus file.
    typedef struct packed {
        cpuPkg::exMemBundle_t stim;
        cpuPkg::regWrite_t    expCommit;
        cpuPkg::regAddr_t     rdReg;     // read two cycles later.
        cpuPkg::word_t        rdExp;
    } testVec_t;

    logic                 clk;
    logic                 rstN;
    cpuPkg::exMemBundle_t exIn;
    cpuPkg::regAddr_t     rdAddr;
    cpuPkg::word_t        rdData;
    cpuPkg::regWrite_t    commit;

    testVec_t vecs [$];
    bit       loaded = 1'b0; // starts the watchdog.

    memWbTop memWbTop_inst (
        .clk    (clk),
        .rstN   (rstN),
        .exIn   (exIn),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .commit (commit)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // fills vecs, skips comment and blank lines.
    task automatic loadVectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [11];
        testVec_t    v;
        fd = $fopen("test/memWbInput.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/memWbInput.txt");
            $display("Test FAILED");
            $fatal(1, "stimulus file missing");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (n != 11) begin
                        $display("malformed line in the stimulus file: %s", line);
                        $display("Test FAILED");
                        $fatal(1, "bad stimulus line");
                    end else begin
                        v.stim.valid        = 1'b1;
                        v.stim.instr        = f[0];
                        v.stim.pc           = f[1];
                        v.stim.aluResult    = f[2];
                        v.stim.storeData    = f[3];
                        v.stim.regWriteAddr = f[4][4:0];
                        v.expCommit.en      = f[5][0];
                        v.expCommit.addr    = f[6][4:0];
                        v.expCommit.data    = f[7];
                        v.expCommit.pc      = f[8];
                        v.rdReg             = f[9][4:0];
                        v.rdExp             = f[10];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // budget from the vector count, one line per cycle.
    initial begin
        wait (loaded);
        #((RESET_CYCLES + vecs.size() + SLACK_CYCLES) * 2 * HALF_PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int n;
        rstN   = 1'b0;
        exIn   = '0;
        rdAddr = '0;
        loadVectors();
        n      = vecs.size();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        // cycle c drives line c, checks commit of c-1 and register of c-2.
        for (int c = 0; c < n + 2; c++) begin
            @(posedge clk);
            if (c < n)
                exIn <= vecs[c].stim;
            else
                exIn <= '0; // bubble after the last line.
            if (c >= 2)
                rdAddr <= vecs[c-2].rdReg;
            @(negedge clk); // outputs settled mid-cycle.
            if (c == 0)
                checkValue("commit.en after reset", commit.en, 1'b0);
            if (c >= 1 && c <= n) begin
                checkValue($sformatf("line %0d commit.en", c - 1), commit.en,
                           vecs[c-1].expCommit.en);
                if (vecs[c-1].expCommit.en) begin
                    checkValue($sformatf("line %0d commit.addr", c - 1), commit.addr,
                               vecs[c-1].expCommit.addr);
                    checkValue($sformatf("line %0d commit.data", c - 1), commit.data,
                               vecs[c-1].expCommit.data);
                    checkValue($sformatf("line %0d commit.pc", c - 1), commit.pc,
                               vecs[c-1].expCommit.pc);
                end
            end
            if (c >= 2)
                checkValue($sformatf("line %0d rdData", c - 2), rdData, vecs[c-2].rdExp);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: source/memWbTop.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memWbTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  cpuPkg::exMemBundle_t exIn,
    input  cpuPkg::regAddr_t     rdAddr,
    output cpuPkg::word_t        rdData,
    output cpuPkg::regWrite_t    commit
);

    cpuPkg::instrClass_t  memClass;
    cpuPkg::accessSize_t  memSize;
    logic [1:0]           offset;
    cpuPkg::byteEn_t      laneEn;
    cpuPkg::byteEn_t      writeEn;
    cpuPkg::word_t        laneData;
    cpuPkg::word_t        readWord;
    cpuPkg::memWbBundle_t wbReg;

    // mem-stage decode.
    instrClassifier instrClassifier_inst (
        .instr        (exIn.instr),
        .instrClass   (memClass),
        .size         (memSize),
        .unsignedLoad ()
    );

    assign offset = exIn.aluResult[1:0];

    // byte lane steering for stores.
    always_comb begin
        case (memSize)
            cpuPkg::SIZE_BYTE: begin
                laneData = {4{exIn.storeData[`BYTE_WIDTH-1:0]}}; // byte in every lane.
                laneEn   = cpuPkg::byteEn_t'(1) << offset;
            end
            cpuPkg::SIZE_HALF: begin
                laneData = {2{exIn.storeData[`HALF_WIDTH-1:0]}};
                laneEn   = offset[1] ? 4'b1100 : 4'b0011; // upper or lower half.
            end
            default: begin
                laneData = exIn.storeData;
                laneEn   = 4'b1111;
            end
        endcase
    end

    // only a valid store touches memory.
    assign writeEn = (exIn.valid && (memClass == cpuPkg::CLASS_STORE)) ? laneEn : '0;

    dataMemory dataMemory_inst (
        .clk       (clk),
        .wordAddr  (exIn.aluResult[`DMEM_ADDR_WIDTH+1:2]), // word index.
        .writeEn   (writeEn),
        .writeData (laneData),
        .readData  (readWord)
    );

    // mem/wb register, same edge as the ram read.
    always_ff @(posedge clk) begin
        if (!rstN)
            wbReg.valid <= 1'b0;
        else
            wbReg.valid <= exIn.valid;
        wbReg.instr        <= exIn.instr;
        wbReg.pc           <= exIn.pc;
        wbReg.aluResult    <= exIn.aluResult;
        wbReg.regWriteAddr <= exIn.regWriteAddr;
    end

    writeBackStage writeBackStage_inst (
        .wbIn    (wbReg),
        .memWord (readWord),
        .wbOut   (commit)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .wr     (commit), // commit record doubles as write port.
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::regWrite_t wr,
    input  cpuPkg::regAddr_t  rdAddr,
    output cpuPkg::word_t     rdData
);

    localparam int NUM_REGS = 2 ** $bits(cpuPkg::regAddr_t);

    cpuPkg::word_t regs [1:NUM_REGS-1]; // no storage for $0.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // combinational read.
    // no write-through, new value shows after the edge.
    always_comb begin
        if (rdAddr == '0)
            rdData = '0; // $0 hard-wired.
        else
            rdData = regs[rdAddr];
    end

endmodule

// File: source/writeBackStage.sv
`timescale 1ns/1ps

module writeBackStage (
    input  cpuPkg::memWbBundle_t wbIn,
    input  cpuPkg::word_t        memWord,
    output cpuPkg::regWrite_t    wbOut
);

    cpuPkg::instrClass_t instrClass;
    cpuPkg::accessSize_t size;
    logic                unsignedLoad;
    cpuPkg::word_t       extWord;
    logic                writesReg;

    // second decode of the same instruction, now in wb.
    instrClassifier instrClassifier_inst (
        .instr        (wbIn.instr),
        .instrClass   (instrClass),
        .size         (size),
        .unsignedLoad (unsignedLoad)
    );

    loadExtender loadExtender_inst (
        .memWord      (memWord),
        .offset       (wbIn.aluResult[1:0]), // byte offset of the load.
        .size         (size),
        .unsignedLoad (unsignedLoad),
        .extWord      (extWord)
    );

    assign writesReg = (instrClass == cpuPkg::CLASS_ALU) ||
                       (instrClass == cpuPkg::CLASS_LOAD);

    // $0 writes are dropped here, never reach the gpr.
    assign wbOut.en   = wbIn.valid && writesReg && (wbIn.regWriteAddr != '0);
    assign wbOut.addr = wbIn.regWriteAddr;
    assign wbOut.data = (instrClass == cpuPkg::CLASS_LOAD) ? extWord : wbIn.aluResult;
    assign wbOut.pc   = wbIn.pc;

endmodule

// File: source/loadExtender.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module loadExtender (
    input  cpuPkg::word_t       memWord,
    input  logic [1:0]          offset,
    input  cpuPkg::accessSize_t size,
    input  logic                unsignedLoad,
    output cpuPkg::word_t       extWord
);

    logic [`BYTE_WIDTH-1:0] selByte;
    logic [`HALF_WIDTH-1:0] selHalf;
    logic                   byteSign;
    logic                   halfSign;

    // lane select, offsets assumed aligned.
    assign selByte = memWord[offset*`BYTE_WIDTH +: `BYTE_WIDTH];
    assign selHalf = memWord[offset[1]*`HALF_WIDTH +: `HALF_WIDTH];

    // fill bit, forced low for lbu/lhu.
    assign byteSign = selByte[`BYTE_WIDTH-1] & ~unsignedLoad;
    assign halfSign = selHalf[`HALF_WIDTH-1] & ~unsignedLoad;

    always_comb begin
        case (size)
            cpuPkg::SIZE_BYTE:
                extWord = {{(`WORD_WIDTH-`BYTE_WIDTH){byteSign}}, selByte};
            cpuPkg::SIZE_HALF:
                extWord = {{(`WORD_WIDTH-`HALF_WIDTH){halfSign}}, selHalf};
            default:
                extWord = memWord; // lw, untouched.
        endcase
    end

endmodule

// File: source/dataMemory.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module dataMemory (
    input  logic                        clk,
    input  logic [`DMEM_ADDR_WIDTH-1:0] wordAddr,
    input  cpuPkg::byteEn_t             writeEn,
    input  cpuPkg::word_t               writeData,
    output cpuPkg::word_t               readData
);

    localparam int LANES = `WORD_WIDTH / `BYTE_WIDTH;

    cpuPkg::word_t mem [`DMEM_WORDS]; // word organized storage.

    // simulation ram, starts cleared.
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // per-lane write.
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (writeEn[lane])
                mem[wordAddr][lane*`BYTE_WIDTH +: `BYTE_WIDTH] <=
                    writeData[lane*`BYTE_WIDTH +: `BYTE_WIDTH];
        end
    end

    // registered read, old data on a same-edge write.
    always_ff @(posedge clk) begin
        readData <= mem[wordAddr];
    end

endmodule

// File: source/instrClassifier.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instrClassifier (
    input  cpuPkg::instr_t      instr,
    output cpuPkg::instrClass_t instrClass,
    output cpuPkg::accessSize_t size,
    output logic                unsignedLoad
);

    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`FUNCT_WIDTH-1:0]  funct;

    assign opcode = instr[`WORD_WIDTH-1 -: `OPCODE_WIDTH]; // bits 31:26.
    assign funct  = instr[`FUNCT_WIDTH-1:0];               // bits 5:0.

    always_comb begin
        // defaults cover every register-writing non-memory op.
        instrClass   = cpuPkg::CLASS_ALU;
        size         = cpuPkg::SIZE_WORD;
        unsignedLoad = 1'b0;
        case (opcode)
            `OP_LW: begin
                instrClass = cpuPkg::CLASS_LOAD;
            end
            `OP_LH, `OP_LHU: begin
                instrClass   = cpuPkg::CLASS_LOAD;
                size         = cpuPkg::SIZE_HALF;
                unsignedLoad = (opcode == `OP_LHU); // zero extend.
            end
            `OP_LB, `OP_LBU: begin
                instrClass   = cpuPkg::CLASS_LOAD;
                size         = cpuPkg::SIZE_BYTE;
                unsignedLoad = (opcode == `OP_LBU);
            end
            `OP_SW: instrClass = cpuPkg::CLASS_STORE;
            `OP_SH: begin
                instrClass = cpuPkg::CLASS_STORE;
                size       = cpuPkg::SIZE_HALF;
            end
            `OP_SB: begin
                instrClass = cpuPkg::CLASS_STORE;
                size       = cpuPkg::SIZE_BYTE;
            end
            `OP_SPECIAL: begin
                if (funct == `FUNCT_NOP)
                    instrClass = cpuPkg::CLASS_NONE; // nop slot.
            end
            default: ; // alu class.
        endcase
    end

endmodule

// File: source/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;     // data word or pc.
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;  // gpr index.
    typedef logic [`WORD_WIDTH-1:0]     instr_t;    // raw instruction.
    typedef logic [`WORD_WIDTH/8-1:0]   byteEn_t;   // one bit per lane.

    // coarse class, decides what write-back does.
    typedef enum logic [1:0] {
        CLASS_ALU,   // writes execute result.
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_NONE   // no register write.
    } instrClass_t;

    typedef enum logic [1:0] {
        SIZE_WORD,
        SIZE_HALF,
        SIZE_BYTE
    } accessSize_t;

    // execute stage output, sampled every cycle.
    typedef struct packed {
        logic     valid;
        instr_t   instr;
        word_t    pc;
        word_t    aluResult;     // address for mem ops, value otherwise.
        word_t    storeData;
        regAddr_t regWriteAddr;
    } exMemBundle_t;

    // mem/wb pipeline register contents; read word comes from ram.
    typedef struct packed {
        logic     valid;
        instr_t   instr;
        word_t    pc;
        word_t    aluResult;
        regAddr_t regWriteAddr;
    } memWbBundle_t;

    // commit record, also the gpr write port.
    typedef struct packed {
        logic     en;
        regAddr_t addr;
        word_t    data;
        word_t    pc;
    } regWrite_t;

endpackage

// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths.
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define BYTE_WIDTH      8
`define HALF_WIDTH      16

// data memory geometry, word organized.
`define DMEM_WORDS      1024
`define DMEM_ADDR_WIDTH 10

// instruction field widths.
`define OPCODE_WIDTH    6
`define FUNCT_WIDTH     6

// load opcodes.
`define OP_LW           6'h23
`define OP_LH           6'h21
`define OP_LHU          6'h25
`define OP_LB           6'h20
`define OP_LBU          6'h24

// store opcodes.
`define OP_SW           6'h2b
`define OP_SH           6'h29
`define OP_SB           6'h28

// r-type space, funct 0 under it is the nop slot.
`define OP_SPECIAL      6'h00
`define FUNCT_NOP       6'h00

`endif
